// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [1:0]      wb_sel_t;

    // ALU operations
    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_and  = 4'd2;
    localparam alu_op_t alu_or   = 4'd3;
    localparam alu_op_t alu_xor  = 4'd4;
    localparam alu_op_t alu_slt  = 4'd5;
    localparam alu_op_t alu_sltu = 4'd6;
    localparam alu_op_t alu_sll  = 4'd7;
    localparam alu_op_t alu_srl  = 4'd8;
    localparam alu_op_t alu_sra  = 4'd9;

    // Major opcodes of the supported subset
    localparam opcode_t op_reg   = 7'b0110011;
    localparam opcode_t op_imm   = 7'b0010011;
    localparam opcode_t op_lui   = 7'b0110111;
    localparam opcode_t op_load  = 7'b0000011;
    localparam opcode_t op_store = 7'b0100011;
    localparam opcode_t op_br    = 7'b1100011;

    // Function codes
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;
    localparam funct3_t f3_word    = 3'b010;
    localparam funct3_t f3_beq     = 3'b000;
    localparam funct3_t f3_bne     = 3'b001;

    // Writeback source
    localparam wb_sel_t wb_alu = 2'd0;
    localparam wb_sel_t wb_imm = 2'd1;
    localparam wb_sel_t wb_mem = 2'd2;

    localparam word_t reset_pc = 32'h0000_0000;
    localparam word_t pc_step  = 32'd4;

endpackage

// ==== hw/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
    input  logic          clk,
    input  logic          i_arst_n,
    input  logic          i_en,
    input  logic          i_squash,
    input  logic          i_br_taken,
    input  rv_pkg::word_t i_br_target,
    input  rv_pkg::word_t i_imem_rdata,
    output rv_pkg::word_t o_imem_addr,
    output rv_pkg::word_t o_id_pc,
    output rv_pkg::word_t o_id_instr,
    output logic          o_id_valid
);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc_next;

    // Taken branch in execute overrides sequential fetch
    assign pc_next     = i_br_taken ? i_br_target : pc + rv_pkg::pc_step;
    assign o_imem_addr = pc;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc         <= rv_pkg::reset_pc;
            o_id_pc    <= '0;
            o_id_instr <= '0;
            o_id_valid <= 1'b0;
        end else if (i_en) begin
            pc         <= pc_next;
            o_id_pc    <= pc;
            o_id_instr <= i_imem_rdata;
            // Wrong-path fetch is dropped here
            o_id_valid <= !i_squash;
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_en,
    input  logic             i_squash,
    input  rv_pkg::word_t    i_id_pc,
    input  rv_pkg::word_t    i_id_instr,
    input  logic             i_id_valid,
    input  rv_pkg::word_t    i_rs1_data,
    input  rv_pkg::word_t    i_rs2_data,
    output rv_pkg::reg_idx_t o_rs1,
    output rv_pkg::reg_idx_t o_rs2,
    output logic             o_ex_valid,
    output rv_pkg::word_t    o_ex_pc,
    output rv_pkg::reg_idx_t o_ex_rs1,
    output rv_pkg::reg_idx_t o_ex_rs2,
    output rv_pkg::reg_idx_t o_ex_rd,
    output rv_pkg::word_t    o_ex_rs1_data,
    output rv_pkg::word_t    o_ex_rs2_data,
    output rv_pkg::word_t    o_ex_imm,
    output rv_pkg::alu_op_t  o_ex_alu_op,
    output logic             o_ex_use_imm,
    output logic             o_ex_is_load,
    output logic             o_ex_is_store,
    output logic             o_ex_is_branch,
    output logic             o_ex_br_ne,
    output rv_pkg::wb_sel_t  o_ex_wb_sel,
    output logic             o_ex_reg_write
);

    rv_pkg::opcode_t opcode;
    rv_pkg::funct3_t f3;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm;
    rv_pkg::alu_op_t alu_op;
    rv_pkg::wb_sel_t wb_sel;
    logic            known;
    logic            use_imm;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            reg_write;
    logic            keep;

    // alt selects sub or sra
    function automatic rv_pkg::alu_op_t alu_fn(rv_pkg::funct3_t fn, logic alt);
        case (fn)
            rv_pkg::f3_add_sub: return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:     return rv_pkg::alu_sll;
            rv_pkg::f3_slt:     return rv_pkg::alu_slt;
            rv_pkg::f3_sltu:    return rv_pkg::alu_sltu;
            rv_pkg::f3_xor:     return rv_pkg::alu_xor;
            rv_pkg::f3_srl_sra: return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:      return rv_pkg::alu_or;
            default:            return rv_pkg::alu_and;
        endcase
    endfunction

    assign opcode = i_id_instr[6:0];
    assign f3     = i_id_instr[14:12];
    assign o_rs1  = i_id_instr[19:15];
    assign o_rs2  = i_id_instr[24:20];

    assign imm_i = {{20{i_id_instr[31]}}, i_id_instr[31:20]};
    assign imm_s = {{20{i_id_instr[31]}}, i_id_instr[31:25], i_id_instr[11:7]};
    assign imm_b = {{19{i_id_instr[31]}}, i_id_instr[31], i_id_instr[7],
                    i_id_instr[30:25], i_id_instr[11:8], 1'b0};
    assign imm_u = {i_id_instr[31:12], 12'b0};

    always_comb begin
        known     = 1'b1;
        imm       = imm_i;
        alu_op    = rv_pkg::alu_add;
        wb_sel    = rv_pkg::wb_alu;
        use_imm   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            rv_pkg::op_reg: begin
                alu_op    = alu_fn(f3, i_id_instr[30]);
                reg_write = 1'b1;
            end
            rv_pkg::op_imm: begin
                // Bit 30 is immediate data except on shifts
                alu_op    = alu_fn(f3, i_id_instr[30] && f3 == rv_pkg::f3_srl_sra);
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::op_lui: begin
                imm       = imm_u;
                wb_sel    = rv_pkg::wb_imm;
                reg_write = 1'b1;
            end
            rv_pkg::op_load: begin
                known     = (f3 == rv_pkg::f3_word);
                use_imm   = 1'b1;
                is_load   = 1'b1;
                wb_sel    = rv_pkg::wb_mem;
                reg_write = 1'b1;
            end
            rv_pkg::op_store: begin
                known    = (f3 == rv_pkg::f3_word);
                imm      = imm_s;
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            rv_pkg::op_br: begin
                known     = (f3 == rv_pkg::f3_beq) || (f3 == rv_pkg::f3_bne);
                imm       = imm_b;
                is_branch = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // Unsupported encodings travel on as bubbles
    assign keep = i_id_valid && known && !i_squash;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_valid     <= 1'b0;
            o_ex_pc        <= '0;
            o_ex_rs1       <= '0;
            o_ex_rs2       <= '0;
            o_ex_rd        <= '0;
            o_ex_rs1_data  <= '0;
            o_ex_rs2_data  <= '0;
            o_ex_imm       <= '0;
            o_ex_alu_op    <= rv_pkg::alu_add;
            o_ex_use_imm   <= 1'b0;
            o_ex_is_load   <= 1'b0;
            o_ex_is_store  <= 1'b0;
            o_ex_is_branch <= 1'b0;
            o_ex_br_ne     <= 1'b0;
            o_ex_wb_sel    <= rv_pkg::wb_alu;
            o_ex_reg_write <= 1'b0;
        end else if (i_en) begin
            o_ex_valid     <= keep;
            o_ex_pc        <= i_id_pc;
            o_ex_rs1       <= o_rs1;
            o_ex_rs2       <= o_rs2;
            o_ex_rd        <= i_id_instr[11:7];
            o_ex_rs1_data  <= i_rs1_data;
            o_ex_rs2_data  <= i_rs2_data;
            o_ex_imm       <= imm;
            o_ex_alu_op    <= alu_op;
            o_ex_use_imm   <= use_imm;
            o_ex_is_load   <= is_load && keep;
            o_ex_is_store  <= is_store && keep;
            o_ex_is_branch <= is_branch && keep;
            o_ex_br_ne     <= (f3 == rv_pkg::f3_bne);
            o_ex_wb_sel    <= wb_sel;
            o_ex_reg_write <= reg_write && keep;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic             clk,
    input  logic             i_arst_n,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    output rv_pkg::word_t    o_rs1_data,
    output rv_pkg::word_t    o_rs2_data,
    input  logic             i_we,
    input  rv_pkg::reg_idx_t i_rd,
    input  rv_pkg::word_t    i_wdata
);

    rv_pkg::word_t regs [32];
    logic          wr_live;

    assign wr_live = i_we && (i_rd != 5'd0);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Same-cycle write is visible to decode
    assign o_rs1_data = (wr_live && i_rd == i_rs1) ? i_wdata : regs[i_rs1];
    assign o_rs2_data = (wr_live && i_rd == i_rs2) ? i_wdata : regs[i_rs2];

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_en,
    input  logic             i_squash,
    input  logic             i_ex_valid,
    input  rv_pkg::word_t    i_ex_pc,
    input  rv_pkg::reg_idx_t i_ex_rs1,
    input  rv_pkg::reg_idx_t i_ex_rs2,
    input  rv_pkg::reg_idx_t i_ex_rd,
    input  rv_pkg::word_t    i_ex_rs1_data,
    input  rv_pkg::word_t    i_ex_rs2_data,
    input  rv_pkg::word_t    i_ex_imm,
    input  rv_pkg::alu_op_t  i_ex_alu_op,
    input  logic             i_ex_use_imm,
    input  logic             i_ex_is_load,
    input  logic             i_ex_is_store,
    input  logic             i_ex_is_branch,
    input  logic             i_ex_br_ne,
    input  rv_pkg::wb_sel_t  i_ex_wb_sel,
    input  logic             i_ex_reg_write,
    input  rv_pkg::reg_idx_t i_mem_rd,
    input  logic             i_mem_reg_write,
    input  rv_pkg::word_t    i_mem_result,
    input  rv_pkg::reg_idx_t i_wb_rd,
    input  logic             i_wb_reg_write,
    input  rv_pkg::word_t    i_wb_result,
    output logic             o_br_taken,
    output rv_pkg::word_t    o_br_target,
    output rv_pkg::reg_idx_t o_load_rd,
    output logic             o_is_load,
    output logic             o_mem_valid,
    output rv_pkg::reg_idx_t o_mem_rd,
    output rv_pkg::word_t    o_mem_alu,
    output rv_pkg::word_t    o_mem_store_data,
    output rv_pkg::word_t    o_mem_imm,
    output logic             o_mem_is_load,
    output logic             o_mem_is_store,
    output rv_pkg::wb_sel_t  o_mem_wb_sel,
    output logic             o_mem_reg_write
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b_reg;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_out;
    logic          keep;

    // Newest producer wins, memory stage before writeback
    function automatic rv_pkg::word_t fwd(rv_pkg::reg_idx_t src, rv_pkg::word_t rf_val);
        if (i_mem_reg_write && i_mem_rd != 5'd0 && i_mem_rd == src) begin
            return i_mem_result;
        end
        if (i_wb_reg_write && i_wb_rd != 5'd0 && i_wb_rd == src) begin
            return i_wb_result;
        end
        return rf_val;
    endfunction

    assign op_a     = fwd(i_ex_rs1, i_ex_rs1_data);
    assign op_b_reg = fwd(i_ex_rs2, i_ex_rs2_data);
    assign op_b     = i_ex_use_imm ? i_ex_imm : op_b_reg;

    always_comb begin
        case (i_ex_alu_op)
            rv_pkg::alu_sub:  alu_out = op_a - op_b;
            rv_pkg::alu_and:  alu_out = op_a & op_b;
            rv_pkg::alu_or:   alu_out = op_a | op_b;
            rv_pkg::alu_xor:  alu_out = op_a ^ op_b;
            rv_pkg::alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu: alu_out = {31'b0, op_a < op_b};
            rv_pkg::alu_sll:  alu_out = op_a << op_b[4:0];
            rv_pkg::alu_srl:  alu_out = op_a >> op_b[4:0];
            rv_pkg::alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
            default:          alu_out = op_a + op_b;
        endcase
    end

    // beq on equal, bne on not equal
    assign o_br_taken  = i_ex_valid && i_ex_is_branch && ((op_a == op_b_reg) != i_ex_br_ne);
    assign o_br_target = i_ex_pc + i_ex_imm;

    assign o_load_rd = i_ex_rd;
    assign o_is_load = i_ex_valid && i_ex_is_load;

    assign keep = i_ex_valid && !i_squash;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_valid      <= 1'b0;
            o_mem_rd         <= '0;
            o_mem_alu        <= '0;
            o_mem_store_data <= '0;
            o_mem_imm        <= '0;
            o_mem_is_load    <= 1'b0;
            o_mem_is_store   <= 1'b0;
            o_mem_wb_sel     <= rv_pkg::wb_alu;
            o_mem_reg_write  <= 1'b0;
        end else if (i_en) begin
            o_mem_valid      <= keep;
            o_mem_rd         <= i_ex_rd;
            o_mem_alu        <= alu_out;
            o_mem_store_data <= op_b_reg;
            o_mem_imm        <= i_ex_imm;
            o_mem_is_load    <= i_ex_is_load && keep;
            o_mem_is_store   <= i_ex_is_store && keep;
            o_mem_wb_sel     <= i_ex_wb_sel;
            o_mem_reg_write  <= i_ex_reg_write && keep;
        end
    end

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_en,
    input  logic             i_mem_valid,
    input  rv_pkg::reg_idx_t i_mem_rd,
    input  rv_pkg::word_t    i_mem_alu,
    input  rv_pkg::word_t    i_mem_store_data,
    input  rv_pkg::word_t    i_mem_imm,
    input  logic             i_mem_is_load,
    input  logic             i_mem_is_store,
    input  rv_pkg::wb_sel_t  i_mem_wb_sel,
    input  logic             i_mem_reg_write,
    input  rv_pkg::word_t    i_dmem_rdata,
    output rv_pkg::word_t    o_dmem_addr,
    output logic             o_dmem_rd,
    output logic             o_dmem_wr,
    output rv_pkg::word_t    o_dmem_wdata,
    output rv_pkg::word_t    o_result,
    output rv_pkg::reg_idx_t o_wb_rd,
    output logic             o_wb_reg_write,
    output rv_pkg::word_t    o_wb_result
);

    // Word accesses only
    assign o_dmem_addr  = {i_mem_alu[31:2], 2'b00};
    assign o_dmem_rd    = i_mem_valid && i_mem_is_load;
    assign o_dmem_wr    = i_mem_valid && i_mem_is_store;
    assign o_dmem_wdata = i_mem_store_data;

    always_comb begin
        case (i_mem_wb_sel)
            rv_pkg::wb_imm: o_result = i_mem_imm;
            rv_pkg::wb_mem: o_result = i_dmem_rdata;
            default:        o_result = i_mem_alu;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_rd        <= '0;
            o_wb_reg_write <= 1'b0;
            o_wb_result    <= '0;
        end else if (i_en) begin
            o_wb_rd        <= i_mem_rd;
            o_wb_reg_write <= i_mem_valid && i_mem_reg_write;
            o_wb_result    <= o_result;
        end
    end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
    input  logic             i_imem_resp,
    input  logic             i_dmem_resp,
    input  logic             i_dmem_busy,
    input  logic             i_br_taken,
    input  logic             i_ex_is_load,
    input  rv_pkg::reg_idx_t i_ex_rd,
    input  rv_pkg::reg_idx_t i_id_rs1,
    input  rv_pkg::reg_idx_t i_id_rs2,
    output logic             o_en_if,
    output logic             o_en_id,
    output logic             o_en_ex,
    output logic             o_en_mem,
    output logic             o_stall_id,
    output logic             o_squash
);

    logic freeze;
    logic load_use;

    // Either port still owes a response
    assign freeze = !i_imem_resp || (i_dmem_busy && !i_dmem_resp);

    // Consumer waits in decode one cycle for the load data
    assign load_use = i_ex_is_load && (i_ex_rd != 5'd0)
                      && (i_ex_rd == i_id_rs1 || i_ex_rd == i_id_rs2);

    assign o_en_if  = !freeze && !load_use;
    assign o_en_id  = !freeze;
    assign o_en_ex  = !freeze;
    assign o_en_mem = !freeze;

    // ID/EX takes a bubble on a load-use hold or a redirect
    assign o_stall_id = load_use || i_br_taken;
    assign o_squash   = i_br_taken;

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
    input  logic          clk,
    input  logic          i_arst_n,
    output rv_pkg::word_t o_imem_addr,
    input  logic          i_imem_resp,
    input  rv_pkg::word_t i_imem_rdata,
    output rv_pkg::word_t o_dmem_addr,
    output logic          o_dmem_rd,
    output logic          o_dmem_wr,
    output rv_pkg::word_t o_dmem_wdata,
    input  logic          i_dmem_resp,
    input  rv_pkg::word_t i_dmem_rdata
);

    logic en_if, en_id, en_ex, en_mem, stall_id, squash, dmem_busy;
    logic br_taken, ex_is_load;
    rv_pkg::word_t br_target;
    rv_pkg::reg_idx_t load_rd;

    rv_pkg::word_t id_pc, id_instr, rs1_data, rs2_data;
    logic id_valid;
    rv_pkg::reg_idx_t id_rs1, id_rs2;

    rv_pkg::word_t ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    rv_pkg::reg_idx_t ex_rs1, ex_rs2, ex_rd;
    rv_pkg::alu_op_t ex_alu_op;
    rv_pkg::wb_sel_t ex_wb_sel;
    logic ex_valid, ex_use_imm, ex_is_load_q, ex_is_store, ex_is_branch, ex_br_ne;
    logic ex_reg_write;

    rv_pkg::word_t mem_alu, mem_store_data, mem_imm, mem_result;
    rv_pkg::reg_idx_t mem_rd;
    rv_pkg::wb_sel_t mem_wb_sel;
    logic mem_valid, mem_is_load, mem_is_store, mem_reg_write;

    rv_pkg::word_t wb_result;
    rv_pkg::reg_idx_t wb_rd;
    logic wb_reg_write;

    assign dmem_busy = o_dmem_rd || o_dmem_wr;

    fetch_stage u_fetch (
        .clk, .i_arst_n, .i_en(en_if), .i_squash(squash),
        .i_br_taken(br_taken), .i_br_target(br_target),
        .i_imem_rdata, .o_imem_addr,
        .o_id_pc(id_pc), .o_id_instr(id_instr), .o_id_valid(id_valid)
    );

    decode_stage u_decode (
        .clk, .i_arst_n, .i_en(en_id), .i_squash(stall_id),
        .i_id_pc(id_pc), .i_id_instr(id_instr), .i_id_valid(id_valid),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .o_rs1(id_rs1), .o_rs2(id_rs2),
        .o_ex_valid(ex_valid), .o_ex_pc(ex_pc), .o_ex_rs1(ex_rs1), .o_ex_rs2(ex_rs2),
        .o_ex_rd(ex_rd), .o_ex_rs1_data(ex_rs1_data), .o_ex_rs2_data(ex_rs2_data),
        .o_ex_imm(ex_imm), .o_ex_alu_op(ex_alu_op), .o_ex_use_imm(ex_use_imm),
        .o_ex_is_load(ex_is_load_q), .o_ex_is_store(ex_is_store),
        .o_ex_is_branch(ex_is_branch), .o_ex_br_ne(ex_br_ne),
        .o_ex_wb_sel(ex_wb_sel), .o_ex_reg_write(ex_reg_write)
    );

    reg_file u_regs (
        .clk, .i_arst_n, .i_rs1(id_rs1), .i_rs2(id_rs2),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_we(wb_reg_write), .i_rd(wb_rd), .i_wdata(wb_result)
    );

    execute_stage u_execute (
        .clk, .i_arst_n, .i_en(en_ex), .i_squash(squash),
        .i_ex_valid(ex_valid), .i_ex_pc(ex_pc), .i_ex_rs1(ex_rs1), .i_ex_rs2(ex_rs2),
        .i_ex_rd(ex_rd), .i_ex_rs1_data(ex_rs1_data), .i_ex_rs2_data(ex_rs2_data),
        .i_ex_imm(ex_imm), .i_ex_alu_op(ex_alu_op), .i_ex_use_imm(ex_use_imm),
        .i_ex_is_load(ex_is_load_q), .i_ex_is_store(ex_is_store),
        .i_ex_is_branch(ex_is_branch), .i_ex_br_ne(ex_br_ne),
        .i_ex_wb_sel(ex_wb_sel), .i_ex_reg_write(ex_reg_write),
        .i_mem_rd(mem_rd), .i_mem_reg_write(mem_reg_write), .i_mem_result(mem_result),
        .i_wb_rd(wb_rd), .i_wb_reg_write(wb_reg_write), .i_wb_result(wb_result),
        .o_br_taken(br_taken), .o_br_target(br_target),
        .o_load_rd(load_rd), .o_is_load(ex_is_load),
        .o_mem_valid(mem_valid), .o_mem_rd(mem_rd), .o_mem_alu(mem_alu),
        .o_mem_store_data(mem_store_data), .o_mem_imm(mem_imm),
        .o_mem_is_load(mem_is_load), .o_mem_is_store(mem_is_store),
        .o_mem_wb_sel(mem_wb_sel), .o_mem_reg_write(mem_reg_write)
    );

    mem_stage u_mem (
        .clk, .i_arst_n, .i_en(en_mem),
        .i_mem_valid(mem_valid), .i_mem_rd(mem_rd), .i_mem_alu(mem_alu),
        .i_mem_store_data(mem_store_data), .i_mem_imm(mem_imm),
        .i_mem_is_load(mem_is_load), .i_mem_is_store(mem_is_store),
        .i_mem_wb_sel(mem_wb_sel), .i_mem_reg_write(mem_reg_write),
        .i_dmem_rdata, .o_dmem_addr, .o_dmem_rd, .o_dmem_wr, .o_dmem_wdata,
        .o_result(mem_result), .o_wb_rd(wb_rd), .o_wb_reg_write(wb_reg_write),
        .o_wb_result(wb_result)
    );

    hazard_unit u_hazard (
        .i_imem_resp, .i_dmem_resp, .i_dmem_busy(dmem_busy),
        .i_br_taken(br_taken), .i_ex_is_load(ex_is_load), .i_ex_rd(load_rd),
        .i_id_rs1(id_rs1), .i_id_rs2(id_rs2),
        .o_en_if(en_if), .o_en_id(en_id), .o_en_ex(en_ex), .o_en_mem(en_mem),
        .o_stall_id(stall_id), .o_squash(squash)
    );

endmodule

// ==== tests/rv_core_assert.sv ====
`timescale 1ns/10ps

module rv_core_assert (
    input logic          clk,
    input logic          i_arst_n,
    input rv_pkg::word_t o_imem_addr,
    input rv_pkg::word_t o_dmem_addr,
    input logic          o_dmem_rd,
    input logic          o_dmem_wr,
    input logic          i_dmem_resp
);

    // Only one kind of data access at a time
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(o_dmem_rd && o_dmem_wr))
        else $error("data read and write strobes high together");

    // Fetch and active data addresses stay on word boundaries
    a_addr_align: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_imem_addr[1:0] == 2'b00)
        && (!(o_dmem_rd || o_dmem_wr) || (o_dmem_addr[1:0] == 2'b00)))
        else $error("fetch or data address not word aligned");

    // Pending access keeps strobe and address until answered
    a_addr_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        ((o_dmem_rd || o_dmem_wr) && !i_dmem_resp)
        |=> ((o_dmem_rd || o_dmem_wr) && $stable(o_dmem_addr)))
        else $error("data access dropped or address moved before response");

endmodule

bind rv_core rv_core_assert u_assert (.*);

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb;

    localparam int n_progs   = 40;
    localparam int n_body    = 20;
    localparam int max_wait  = 3000;

    logic          clk;
    logic          i_arst_n;
    logic          i_imem_resp;
    logic          i_dmem_resp;
    rv_pkg::word_t i_imem_rdata;
    rv_pkg::word_t i_dmem_rdata;
    rv_pkg::word_t o_imem_addr;
    rv_pkg::word_t o_dmem_addr;
    logic          o_dmem_rd;
    logic          o_dmem_wr;
    rv_pkg::word_t o_dmem_wdata;

    rv_pkg::word_t imem [64];
    rv_pkg::word_t dmem [256];
    rv_pkg::word_t model_mem [256];
    rv_pkg::word_t mregs [32];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];
    int            kind [32];
    int            rd_f [32];
    int            rs1_f [32];
    int            rs2_f [32];
    int            f3_f [32];
    int            imm_f [32];
    bit            alt_f [32];
    int            halt_idx;
    int            store_idx;
    bit            running;
    string         test_name;
    logic [31:0]   lcg_state = 32'hc70d;

    rv_core i_dut (.*);

    always #50 clk = ~clk;

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function int pick(int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    function rv_pkg::word_t fill_word(int idx);
        return (rv_pkg::word_t'(idx) * 32'h9e37_79b9) ^ 32'h0f1e_c3a5;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(string name, rv_pkg::word_t exp, rv_pkg::word_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(string name, rv_pkg::word_t exp, rv_pkg::word_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // RV32I encoding of one generated slot
    function automatic rv_pkg::word_t encode(int i);
        rv_pkg::reg_idx_t rd;
        rv_pkg::reg_idx_t rs1;
        rv_pkg::reg_idx_t rs2;
        rv_pkg::funct3_t  f3;
        logic [11:0]      i12;
        logic [12:0]      b13;
        logic [6:0]       hi7;
        rd  = rd_f[i][4:0];
        rs1 = rs1_f[i][4:0];
        rs2 = rs2_f[i][4:0];
        f3  = f3_f[i][2:0];
        i12 = imm_f[i][11:0];
        b13 = imm_f[i][12:0];
        hi7 = alt_f[i] ? 7'h20 : 7'h00;
        case (kind[i])
            0: return {hi7, rs2, rs1, f3, rd, rv_pkg::op_reg};
            1: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    i12 = {hi7, imm_f[i][4:0]};
                end
                return {i12, rs1, f3, rd, rv_pkg::op_imm};
            end
            2: return {imm_f[i][19:0], rd, rv_pkg::op_lui};
            3: return {i12, rs1, 3'b010, rd, rv_pkg::op_load};
            4: return {i12[11:5], rs2, rs1, 3'b010, i12[4:0], rv_pkg::op_store};
            default: return {b13[12], b13[10:5], rs2, rs1, f3, b13[4:1], b13[11], rv_pkg::op_br};
        endcase
    endfunction

    function automatic rv_pkg::word_t alu_ref(int f3, bit alt, rv_pkg::word_t a,
                                              rv_pkg::word_t b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return a ^ b;
            5: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic gen_program();
        int sel;
        for (int i = 0; i < n_body; i++) begin
            sel      = pick(10);
            rd_f[i]  = pick(5);
            rs1_f[i] = pick(5);
            rs2_f[i] = pick(5);
            f3_f[i]  = pick(8);
            alt_f[i] = 1'b0;
            // Forward branch needs room for the skipped slots
            if (sel == 9 && i + 2 > n_body - 1) begin
                sel = 0;
            end
            if (sel <= 2) begin
                kind[i]  = 0;
                alt_f[i] = (f3_f[i] == 0 || f3_f[i] == 5) ? bit'(pick(2)) : 1'b0;
            end else if (sel <= 4) begin
                kind[i]  = 1;
                alt_f[i] = (f3_f[i] == 5) ? bit'(pick(2)) : 1'b0;
                imm_f[i] = (f3_f[i] == 1 || f3_f[i] == 5) ? pick(32) : pick(4096) - 2048;
            end else if (sel == 5) begin
                kind[i]  = 2;
                imm_f[i] = pick(1 << 20);
            end else if (sel <= 8) begin
                kind[i]  = (sel == 6) ? 3 : 4;
                imm_f[i] = 4 * pick(64) - 128;
            end else begin
                kind[i]  = 5;
                f3_f[i]  = pick(2);
                imm_f[i] = 4 * (2 + pick(2));
            end
        end
        // Dump x1..x4, then branch-to-self
        for (int k = 0; k < 4; k++) begin
            kind[n_body + k]  = 4;
            rs1_f[n_body + k] = 0;
            rs2_f[n_body + k] = k + 1;
            imm_f[n_body + k] = 512 + 4 * k;
        end
        halt_idx        = n_body + 4;
        kind[halt_idx]  = 5;
        f3_f[halt_idx]  = 0;
        rs1_f[halt_idx] = 0;
        rs2_f[halt_idx] = 0;
        imm_f[halt_idx] = 0;
    endtask

    // Sequential ISA model that records every store
    task automatic run_model();
        int            pc;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t addr;
        pc = 0;
        exp_addr.delete();
        exp_data.delete();
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end
        while (pc != halt_idx) begin
            a    = mregs[rs1_f[pc]];
            b    = mregs[rs2_f[pc]];
            addr = (a + rv_pkg::word_t'(imm_f[pc])) & 32'hffff_fffc;
            case (kind[pc])
                0: mregs[rd_f[pc]] = alu_ref(f3_f[pc], alt_f[pc], a, b);
                1: mregs[rd_f[pc]] = alu_ref(f3_f[pc], alt_f[pc], a,
                                             rv_pkg::word_t'(imm_f[pc]));
                2: mregs[rd_f[pc]] = rv_pkg::word_t'(imm_f[pc]) << 12;
                3: mregs[rd_f[pc]] = model_mem[addr[9:2]];
                4: begin
                    model_mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                default: ;
            endcase
            mregs[0] = '0;
            if (kind[pc] == 5 && ((a == b) != (f3_f[pc] == 1))) begin
                pc = pc + imm_f[pc] / 4;
            end else begin
                pc = pc + 1;
            end
        end
    endtask

    task automatic record_store();
        if (store_idx >= exp_addr.size()) begin
            abort_run($sformatf("%s: unexpected extra store to address %h",
                                test_name, o_dmem_addr));
        end
        check_addr($sformatf("%s store %0d addr", test_name, store_idx),
                   exp_addr[store_idx], o_dmem_addr);
        check_word($sformatf("%s store %0d data", test_name, store_idx),
                   exp_data[store_idx], o_dmem_wdata);
        dmem[o_dmem_addr[9:2]] = o_dmem_wdata;
        store_idx++;
    endtask

    // Memory models answer on the falling edge
    always @(negedge clk) begin
        i_imem_resp  = pick(4) != 0;
        // A data response only lands when fetch also answers
        i_dmem_resp  = i_imem_resp && (pick(3) != 0);
        i_imem_rdata = imem[o_imem_addr[7:2]];
        // Read data only while a load strobe is up
        i_dmem_rdata = o_dmem_rd ? dmem[o_dmem_addr[9:2]] : 32'hdead_beef;
        if (running && o_dmem_wr && i_dmem_resp) begin
            record_store();
        end
    end

    initial begin
        int cycles;
        clk          = 1'b0;
        i_arst_n     = 1'b0;
        i_imem_resp  = 1'b0;
        i_dmem_resp  = 1'b0;
        i_imem_rdata = '0;
        i_dmem_rdata = '0;
        running      = 1'b0;
        store_idx    = 0;
        for (int p = 0; p < n_progs; p++) begin
            @(negedge clk);
            i_arst_n  = 1'b0;
            test_name = $sformatf("prog_%0d", p);
            gen_program();
            for (int i = 0; i < 64; i++) begin
                imem[i] = (i <= halt_idx) ? encode(i) : '0;
            end
            for (int i = 0; i < 256; i++) begin
                dmem[i]      = fill_word(i);
                model_mem[i] = fill_word(i);
            end
            run_model();
            repeat (4) @(negedge clk);
            store_idx = 0;
            running   = 1'b1;
            i_arst_n  = 1'b1;
            cycles    = 0;
            while (o_imem_addr != rv_pkg::word_t'(halt_idx * 4)) begin
                @(negedge clk);
                cycles++;
                if (cycles > max_wait) begin
                    abort_run($sformatf("%s: fetch never reached the final loop", test_name));
                end
            end
            cycles = 0;
            while (store_idx < exp_addr.size()) begin
                @(negedge clk);
                cycles++;
                if (cycles > max_wait) begin
                    abort_run($sformatf("%s: only %0d of %0d stores seen", test_name,
                                        store_idx, exp_addr.size()));
                end
            end
            running = 1'b0;
            for (int i = 0; i < 256; i++) begin
                check_word($sformatf("%s dmem[%0d]", test_name, i), model_mem[i], dmem[i]);
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== rv_core.f ====
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/hazard_unit.sv
hw/rv_core.sv
tests/rv_core_assert.sv
tests/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb \
    --Mdir obj_dir -o sim_rv_core
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "PASS: all tests" sim.log; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
